// File: src/rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

    localparam int xlen = 32;

    // --------------------
    // opcodes
    localparam logic [6:0] op_reg    = 7'b0110011;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_branch = 7'b1100011;

    // --------------------
    // function codes
    localparam logic [2:0] f3_add_sub = 3'b000;
    localparam logic [2:0] f3_xor     = 3'b100;
    localparam logic [2:0] f3_or      = 3'b110;
    localparam logic [2:0] f3_and     = 3'b111;
    localparam logic [2:0] f3_beq     = 3'b000;
    localparam logic [2:0] f3_bne     = 3'b001;

    localparam logic [6:0] funct7_sub = 7'b0100000;

    // --------------------
    // instruction formats
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } b_fmt_t;

    // same 32 bits, seen through each format
    typedef union packed {
        logic [31:0] word;
        r_fmt_t      r_fmt;
        i_fmt_t      i_fmt;
        s_fmt_t      s_fmt;
        b_fmt_t      b_fmt;
    } rv_inst_t;

endpackage

`default_nettype wire

// File: src/rv_mem_pkg.sv
`default_nettype none

package rv_mem_pkg;

    // unified memory geometry
    localparam int mem_words   = 1024;
    localparam int word_addr_w = 10;

    // --------------------
    // memory map
    localparam logic [31:0] reset_vector = 32'h0000_0000;

    // stores here leave the chip, never reach memory
    localparam logic [31:0] tohost_addr  = 32'h0000_1000;

endpackage

`default_nettype wire

// File: src/rv_fetch.sv
`timescale 1ns/1ps
`default_nettype none

module rv_fetch
    import rv_mem_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   redirect,
    input  logic [31:0]            redirect_pc,
    input  logic                   load_stall,
    output logic                   fetch_req,
    output logic [word_addr_w-1:0] fetch_addr,
    input  logic                   fetch_gnt,
    output logic [31:0]            inst_pc
);

    logic        running;
    logic [31:0] pc;
    logic [31:0] req_pc;

    // first request one cycle after rst falls
    always_ff @(posedge clk) begin
        if (rst) begin
            running <= 1'b0;
        end else begin
            running <= 1'b1;
        end
    end

    // taken branch steers this cycle's request
    assign req_pc     = redirect ? redirect_pc : pc;
    assign fetch_req  = running && !load_stall;
    assign fetch_addr = req_pc[word_addr_w+1:2];

    // refused fetch keeps its address for the retry
    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= reset_vector;
        end else if (fetch_gnt) begin
            pc <= req_pc + 32'd4;
        end else if (redirect) begin
            pc <= redirect_pc;
        end
    end

    // pc of the word that comes back next cycle
    always_ff @(posedge clk) begin
        if (fetch_gnt) begin
            inst_pc <= req_pc;
        end
    end

endmodule

`default_nettype wire

// File: src/rv_exec.sv
`timescale 1ns/1ps
`default_nettype none

module rv_exec
    import rv_isa_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        fetch_rvalid,
    input  logic [31:0] inst_pc,
    input  logic [31:0] mem_rdata,
    input  logic        data_rvalid,
    output logic        redirect,
    output logic [31:0] redirect_pc,
    output logic        load_stall,
    output logic        mem_op,
    output logic        mem_store,
    output logic [31:0] mem_addr_byte,
    output logic [31:0] store_data,
    output logic        retire,
    output logic [31:0] retire_pc
);

    rv_inst_t        inst;
    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic            is_reg;
    logic            is_imm;
    logic            is_load;
    logic            is_store;
    logic            is_branch;
    logic [xlen-1:0] rf [32];
    logic [xlen-1:0] rs1_val;
    logic [xlen-1:0] rs2_val;
    logic [xlen-1:0] imm_i;
    logic [xlen-1:0] imm_s;
    logic [xlen-1:0] imm_b;
    logic [xlen-1:0] alu_b;
    logic [xlen-1:0] alu_result;
    logic            branch_cond;
    logic            wr_en;
    logic [4:0]      wr_addr;
    logic [xlen-1:0] wr_data;
    logic            load_pend;
    logic [4:0]      pend_rd;
    logic [31:0]     pend_pc;

    // --------------------
    // decode
    assign inst   = rv_inst_t'(mem_rdata);
    assign opcode = inst.r_fmt.opcode;
    assign funct3 = inst.r_fmt.funct3;

    assign is_reg    = fetch_rvalid && (opcode == op_reg);
    assign is_imm    = fetch_rvalid && (opcode == op_imm);
    assign is_load   = fetch_rvalid && (opcode == op_load);
    assign is_store  = fetch_rvalid && (opcode == op_store);
    assign is_branch = fetch_rvalid && (opcode == op_branch);

    assign imm_i = {{20{inst.i_fmt.imm[11]}}, inst.i_fmt.imm};
    assign imm_s = {{20{inst.s_fmt.imm_hi[6]}}, inst.s_fmt.imm_hi, inst.s_fmt.imm_lo};
    assign imm_b = {{19{inst.b_fmt.imm_12}}, inst.b_fmt.imm_12, inst.b_fmt.imm_11,
                    inst.b_fmt.imm_10_5, inst.b_fmt.imm_4_1, 1'b0};

    // x0 reads as zero
    assign rs1_val = (inst.r_fmt.rs1 == 5'd0) ? '0 : rf[inst.r_fmt.rs1];
    assign rs2_val = (inst.r_fmt.rs2 == 5'd0) ? '0 : rf[inst.r_fmt.rs2];

    // --------------------
    // alu
    assign alu_b = is_reg ? rs2_val : imm_i;

    always_comb begin
        case (funct3)
            f3_add_sub: begin
                if (is_reg && inst.r_fmt.funct7 == funct7_sub) begin
                    alu_result = rs1_val - alu_b;
                end else begin
                    alu_result = rs1_val + alu_b;
                end
            end
            f3_xor:  alu_result = rs1_val ^ alu_b;
            f3_or:   alu_result = rs1_val | alu_b;
            f3_and:  alu_result = rs1_val & alu_b;
            default: alu_result = rs1_val + alu_b;
        endcase
    end

    // --------------------
    // branch resolution
    always_comb begin
        case (funct3)
            f3_beq:  branch_cond = (rs1_val == rs2_val);
            f3_bne:  branch_cond = (rs1_val != rs2_val);
            default: branch_cond = 1'b0;
        endcase
    end

    assign redirect    = is_branch && branch_cond;
    assign redirect_pc = inst_pc + imm_b;

    // load/store request towards the lsu
    assign mem_op        = is_load || is_store;
    assign mem_store     = is_store;
    assign mem_addr_byte = rs1_val + (is_store ? imm_s : imm_i);
    assign store_data    = rs2_val;

    // --------------------
    // register file write
    // load data and an alu result never share a cycle
    always_comb begin
        if (data_rvalid) begin
            wr_en   = 1'b1;
            wr_addr = pend_rd;
            wr_data = mem_rdata;
        end else begin
            wr_en   = is_reg || is_imm;
            wr_addr = inst.r_fmt.rd;
            wr_data = alu_result;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en && wr_addr != 5'd0) begin
            rf[wr_addr] <= wr_data;
        end
    end

    // lw second cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            load_pend <= 1'b0;
        end else begin
            load_pend <= is_load;
        end
    end

    always_ff @(posedge clk) begin
        if (is_load) begin
            pend_rd <= inst.r_fmt.rd;
            pend_pc <= inst_pc;
        end
    end

    assign load_stall = load_pend;

    // a lw retires with its data, everything else on arrival
    assign retire    = (fetch_rvalid && !is_load) || data_rvalid;
    assign retire_pc = data_rvalid ? pend_pc : inst_pc;

endmodule

`default_nettype wire

// File: src/rv_lsu.sv
`timescale 1ns/1ps
`default_nettype none

module rv_lsu
    import rv_mem_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   mem_op,
    input  logic                   mem_store,
    input  logic [31:0]            mem_addr_byte,
    input  logic [31:0]            store_data,
    output logic                   data_req,
    output logic                   data_we,
    output logic [word_addr_w-1:0] data_addr,
    output logic [31:0]            data_wdata,
    input  logic                   data_gnt,
    output logic                   tohost_valid,
    output logic [31:0]            tohost_data
);

    logic                   to_tohost;
    logic                   hold_valid;
    logic                   hold_we;
    logic [word_addr_w-1:0] hold_addr;
    logic [31:0]            hold_wdata;

    // --------------------
    // memory map decode
    assign to_tohost = mem_store && (mem_addr_byte == tohost_addr);

    // refused request is replayed ahead of a new one
    assign data_req   = hold_valid || (mem_op && !to_tohost);
    assign data_we    = hold_valid ? hold_we : mem_store;
    assign data_addr  = hold_valid ? hold_addr : mem_addr_byte[word_addr_w+1:2];
    assign data_wdata = hold_valid ? hold_wdata : store_data;

    always_ff @(posedge clk) begin
        if (rst) begin
            hold_valid   <= 1'b0;
            tohost_valid <= 1'b0;
        end else begin
            hold_valid   <= data_req && !data_gnt;
            tohost_valid <= to_tohost;
        end
    end

    always_ff @(posedge clk) begin
        if (data_req && !data_gnt) begin
            hold_we    <= data_we;
            hold_addr  <= data_addr;
            hold_wdata <= data_wdata;
        end
        if (to_tohost) begin
            tohost_data <= store_data;
        end
    end

endmodule

`default_nettype wire

// File: src/rv_mem_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module rv_mem_arbiter
    import rv_mem_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   load_en,
    input  logic [word_addr_w-1:0] load_addr,
    input  logic [31:0]            load_data,
    input  logic                   data_req,
    input  logic                   data_we,
    input  logic [word_addr_w-1:0] data_addr,
    input  logic [31:0]            data_wdata,
    input  logic                   fetch_req,
    input  logic [word_addr_w-1:0] fetch_addr,
    output logic                   fetch_gnt,
    output logic                   data_gnt,
    output logic                   fetch_rvalid,
    output logic                   data_rvalid,
    output logic                   mem_we,
    output logic [word_addr_w-1:0] mem_addr,
    output logic [31:0]            mem_wdata
);

    logic load_gnt;

    // --------------------
    // fixed priority: load, data, fetch
    // program load only runs during reset
    assign load_gnt  = rst && load_en;
    assign data_gnt  = !load_gnt && data_req;
    assign fetch_gnt = !load_gnt && !data_req && fetch_req;

    assign mem_we    = load_gnt || (data_gnt && data_we);
    assign mem_wdata = load_gnt ? load_data : data_wdata;

    always_comb begin
        if (load_gnt) begin
            mem_addr = load_addr;
        end else if (data_gnt) begin
            mem_addr = data_addr;
        end else begin
            mem_addr = fetch_addr;
        end
    end

    // read owner, tagged one cycle behind the grant
    always_ff @(posedge clk) begin
        if (rst) begin
            fetch_rvalid <= 1'b0;
            data_rvalid  <= 1'b0;
        end else begin
            fetch_rvalid <= fetch_gnt;
            data_rvalid  <= data_gnt && !data_we;
        end
    end

endmodule

`default_nettype wire

// File: src/rv_unified_mem.sv
`timescale 1ns/1ps
`default_nettype none

module rv_unified_mem
    import rv_mem_pkg::*;
(
    input  logic                   clk,
    input  logic                   mem_we,
    input  logic [word_addr_w-1:0] mem_addr,
    input  logic [31:0]            mem_wdata,
    output logic [31:0]            mem_rdata
);

    // instructions and data share this array
    logic [31:0] mem [mem_words];

    // --------------------
    // write port
    always_ff @(posedge clk) begin
        if (mem_we) begin
            mem[mem_addr] <= mem_wdata;
        end
    end

    // registered read, one cycle latency
    always_ff @(posedge clk) begin
        mem_rdata <= mem[mem_addr];
    end

endmodule

`default_nettype wire

// File: src/rv_top.sv
`timescale 1ns/1ps
`default_nettype none

module rv_top
    import rv_mem_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   load_en,
    input  logic [word_addr_w-1:0] load_addr,
    input  logic [31:0]            load_data,
    output logic                   retire,
    output logic [31:0]            retire_pc,
    output logic                   tohost_valid,
    output logic [31:0]            tohost_data
);

    // --------------------
    // fetch side
    logic                   fetch_req;
    logic [word_addr_w-1:0] fetch_addr;
    logic                   fetch_gnt;
    logic                   fetch_rvalid;
    logic [31:0]            inst_pc;
    logic                   redirect;
    logic [31:0]            redirect_pc;
    logic                   load_stall;

    // --------------------
    // data side
    logic                   mem_op;
    logic                   mem_store;
    logic [31:0]            mem_addr_byte;
    logic [31:0]            store_data;
    logic                   data_req;
    logic                   data_we;
    logic [word_addr_w-1:0] data_addr;
    logic [31:0]            data_wdata;
    logic                   data_gnt;
    logic                   data_rvalid;

    // shared memory port
    logic                   mem_we;
    logic [word_addr_w-1:0] mem_addr;
    logic [31:0]            mem_wdata;
    logic [31:0]            mem_rdata;

    rv_fetch       i_rv_fetch       (.*);
    rv_exec        i_rv_exec        (.*);
    rv_lsu         i_rv_lsu         (.*);
    rv_mem_arbiter i_rv_mem_arbiter (.*);
    rv_unified_mem i_rv_unified_mem (.*);

endmodule

`default_nettype wire

// File: bench/rv_arbiter_properties.sv
`timescale 1ns/1ps
`default_nettype none

module rv_arbiter_properties (
    input logic clk,
    input logic rst,
    input logic load_en,
    input logic data_req,
    input logic data_we,
    input logic fetch_req,
    input logic fetch_gnt,
    input logic data_gnt,
    input logic fetch_rvalid,
    input logic data_rvalid
);

    // one owner of the port per cycle
    no_double_grant: assert property (@(posedge clk) disable iff (rst)
        !(fetch_gnt && data_gnt))
        else $error("fetch and data granted in the same cycle");

    fetch_gnt_needs_req: assert property (@(posedge clk) disable iff (rst)
        fetch_gnt |-> fetch_req)
        else $error("fetch grant without a fetch request");

    data_gnt_needs_req: assert property (@(posedge clk) disable iff (rst)
        data_gnt |-> data_req)
        else $error("data grant without a data request");

    // data always wins once program load is over
    data_always_granted: assert property (@(posedge clk) disable iff (rst)
        (data_req && !load_en) |-> data_gnt)
        else $error("data request refused outside program load");

    // --------------------
    // read data tagging
    fetch_rvalid_timing: assert property (@(posedge clk) disable iff (rst)
        fetch_rvalid == $past(fetch_gnt))
        else $error("fetch_rvalid not one cycle after a fetch grant");

    data_rvalid_timing: assert property (@(posedge clk) disable iff (rst)
        data_rvalid == $past(data_gnt && !data_we))
        else $error("data_rvalid not one cycle after a granted data read");

endmodule

bind rv_mem_arbiter rv_arbiter_properties i_rv_arbiter_properties (.*);

`default_nettype wire

// File: bench/rv_top_tb.sv
`timescale 1ns/1ps
`default_nettype none

module rv_top_tb
    import rv_isa_pkg::*;
    import rv_mem_pkg::*;
();

    localparam int n_programs     = 6;
    localparam int max_prog_words = 32;
    localparam int reset_cycles   = max_prog_words + 4;
    localparam int timeout_cycles = n_programs * (max_prog_words * 4 + reset_cycles);
    localparam int max_steps      = 256;
    localparam logic [2:0] f3_word = 3'b010;

    logic                   clk;
    logic                   rst;
    logic                   load_en;
    logic [word_addr_w-1:0] load_addr;
    logic [31:0]            load_data;
    logic                   retire;
    logic [31:0]            retire_pc;
    logic                   tohost_valid;
    logic [31:0]            tohost_data;

    logic [31:0] prog [$];
    logic [31:0] exp_tohost [$];
    logic [31:0] exp_retire [$];
    logic [31:0] lfsr_state;
    int          check_count;
    int          error_count;
    int          retire_idx;
    int          tohost_idx;
    bit          checking;
    bit          prog_done;

    rv_top i_rv_top (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // --------------------
    // random source
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] v;
        int          k;
        v = '0;
        for (k = 0; k < n; k++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    // --------------------
    // instruction encoders
    function automatic logic [31:0] reg_op(input logic [2:0] f3, input logic [6:0] f7,
                                           input int rd, input int rs1, input int rs2);
        return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], op_reg};
    endfunction

    function automatic logic [31:0] imm_op(input int rd, input int rs1, input logic [31:0] imm);
        return {imm[11:0], rs1[4:0], f3_add_sub, rd[4:0], op_imm};
    endfunction

    function automatic logic [31:0] load_op(input int rd, input int rs1, input logic [31:0] imm);
        return {imm[11:0], rs1[4:0], f3_word, rd[4:0], op_load};
    endfunction

    function automatic logic [31:0] store_op(input int rs2, input int rs1, input logic [31:0] imm);
        return {imm[11:5], rs2[4:0], rs1[4:0], f3_word, imm[4:0], op_store};
    endfunction

    function automatic logic [31:0] branch_op(input logic [2:0] f3, input int rs1, input int rs2,
                                              input logic [31:0] off);
        return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3, off[4:1], off[11], op_branch};
    endfunction

    // x31 = tohost address, x30 = data area base
    task automatic tohost_base();
        prog.delete();
        prog.push_back(imm_op(31, 0, 32'd1024));
        prog.push_back(reg_op(f3_add_sub, 7'd0, 31, 31, 31));
        prog.push_back(reg_op(f3_add_sub, 7'd0, 31, 31, 31));
        prog.push_back(imm_op(30, 0, 32'h400));
    endtask

    // --------------------
    // programs
    task automatic alu_mix_program();
        tohost_base();
        prog.push_back(imm_op(1, 0, random_bits(12)));
        prog.push_back(imm_op(2, 0, random_bits(12)));
        prog.push_back(reg_op(f3_add_sub, 7'd0, 3, 1, 2));
        prog.push_back(store_op(3, 31, 0));
        // each one reads the result of the one before
        prog.push_back(reg_op(f3_add_sub, funct7_sub, 4, 3, 1));
        prog.push_back(reg_op(f3_xor, 7'd0, 5, 4, 2));
        prog.push_back(reg_op(f3_or, 7'd0, 6, 5, 1));
        prog.push_back(reg_op(f3_and, 7'd0, 7, 6, 4));
        prog.push_back(store_op(4, 31, 0));
        prog.push_back(store_op(5, 31, 0));
        prog.push_back(store_op(6, 31, 0));
        prog.push_back(store_op(7, 31, 0));
        // writes to x0 must vanish
        prog.push_back(imm_op(0, 1, 32'h123));
        prog.push_back(reg_op(f3_add_sub, 7'd0, 0, 1, 2));
        prog.push_back(store_op(0, 31, 0));
        prog.push_back(branch_op(f3_beq, 0, 0, 0));
    endtask

    task automatic load_store_program();
        tohost_base();
        prog.push_back(imm_op(1, 0, random_bits(12)));
        prog.push_back(imm_op(2, 0, random_bits(12)));
        prog.push_back(store_op(1, 30, 8));
        prog.push_back(store_op(2, 30, 12));
        prog.push_back(load_op(3, 30, 8));
        prog.push_back(reg_op(f3_add_sub, 7'd0, 4, 3, 2));
        prog.push_back(load_op(5, 30, 12));
        prog.push_back(reg_op(f3_add_sub, funct7_sub, 6, 5, 3));
        prog.push_back(store_op(4, 31, 0));
        prog.push_back(store_op(6, 31, 0));
        prog.push_back(store_op(3, 31, 0));
        prog.push_back(branch_op(f3_beq, 0, 0, 0));
    endtask

    task automatic branch_program(input bit equal);
        logic [31:0] delta;
        delta = {random_bits(11), 1'b1};
        tohost_base();
        prog.push_back(imm_op(1, 0, random_bits(12)));
        prog.push_back(imm_op(2, 1, equal ? 32'd0 : delta));
        prog.push_back(imm_op(5, 0, 0));
        // each branch may skip one step of the sum
        prog.push_back(branch_op(f3_beq, 1, 2, 8));
        prog.push_back(imm_op(5, 5, 1));
        prog.push_back(branch_op(f3_bne, 1, 2, 8));
        prog.push_back(imm_op(5, 5, 2));
        prog.push_back(imm_op(5, 5, 4));
        prog.push_back(store_op(5, 31, 0));
        prog.push_back(branch_op(f3_beq, 0, 0, 0));
    endtask

    // --------------------
    // reference model
    function automatic logic [31:0] alu_model(input logic [2:0] f3, input logic sub,
                                              input logic [31:0] x, input logic [31:0] y);
        case (f3)
            f3_add_sub: return sub ? x - y : x + y;
            f3_xor:     return x ^ y;
            f3_or:      return x | y;
            f3_and:     return x & y;
            default:    return x + y;
        endcase
    endfunction

    function automatic void run_reference();
        logic [31:0] regs [32];
        logic [31:0] mem [mem_words];
        logic [31:0] pc;
        logic [31:0] next_pc;
        logic [31:0] w;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm_i;
        logic [31:0] imm_s;
        logic [31:0] imm_b;
        logic [31:0] addr;
        logic        taken;
        logic        running;
        int          k;
        int          steps;
        exp_tohost.delete();
        exp_retire.delete();
        for (k = 0; k < 32; k++) begin
            regs[k] = '0;
        end
        for (k = 0; k < mem_words; k++) begin
            mem[k] = '0;
            if (k < prog.size()) begin
                mem[k] = prog[k];
            end
        end
        pc = reset_vector;
        running = 1'b1;
        steps = 0;
        while (running && steps < max_steps) begin
            w     = mem[pc[word_addr_w+1:2]];
            a     = regs[w[19:15]];
            b     = regs[w[24:20]];
            imm_i = {{20{w[31]}}, w[31:20]};
            imm_s = {{20{w[31]}}, w[31:25], w[11:7]};
            imm_b = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
            taken = (w[14:12] == f3_beq) ? (a == b) : (a != b);
            if (w[6:0] == op_branch && taken && imm_b == 0) begin
                // self-loop ends the program
                running = 1'b0;
            end else begin
                exp_retire.push_back(pc);
                next_pc = pc + 32'd4;
                case (w[6:0])
                    op_reg: regs[w[11:7]] = alu_model(w[14:12], w[31:25] == funct7_sub, a, b);
                    op_imm: regs[w[11:7]] = alu_model(w[14:12], 1'b0, a, imm_i);
                    op_load: begin
                        addr = a + imm_i;
                        regs[w[11:7]] = mem[addr[word_addr_w+1:2]];
                    end
                    op_store: begin
                        addr = a + imm_s;
                        if (addr == tohost_addr) begin
                            exp_tohost.push_back(b);
                        end else begin
                            mem[addr[word_addr_w+1:2]] = b;
                        end
                    end
                    op_branch: begin
                        if (taken) begin
                            next_pc = pc + imm_b;
                        end
                    end
                    default: begin
                    end
                endcase
                regs[0] = '0;
                pc = next_pc;
            end
            steps++;
        end
    endfunction

    // --------------------
    // checking
    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] expected);
        check_count++;
        if (got !== expected) begin
            $display("mismatch %s: got %h, expected %h", name, got, expected);
            error_count++;
        end
    endtask

    always @(negedge clk) begin
        if (checking && !prog_done) begin
            if (tohost_valid) begin
                compare_value("tohost_data", tohost_data, exp_tohost[tohost_idx]);
                tohost_idx++;
                // last store, count everything retired so far
                if (tohost_idx == exp_tohost.size()) begin
                    compare_value("retire_count", retire_idx, exp_retire.size());
                    prog_done = 1'b1;
                end
            end
            if (retire && !prog_done) begin
                if (retire_idx < exp_retire.size()) begin
                    compare_value("retire_pc", retire_pc, exp_retire[retire_idx]);
                end else begin
                    $display("an instruction retired after the expected last one");
                    error_count++;
                end
                retire_idx++;
            end
        end
    end

    // load under reset, then run until the final tohost store
    task automatic run_program();
        int i;
        @(posedge clk);
        rst <= 1'b1;
        for (i = 0; i < prog.size(); i++) begin
            @(posedge clk);
            load_en   <= 1'b1;
            load_addr <= i[word_addr_w-1:0];
            load_data <= prog[i];
        end
        @(posedge clk);
        load_en <= 1'b0;
        repeat (2) @(posedge clk);
        run_reference();
        retire_idx = 0;
        tohost_idx = 0;
        prog_done  = 1'b0;
        checking   = 1'b1;
        rst <= 1'b0;
        while (!prog_done) begin
            @(posedge clk);
        end
        checking = 1'b0;
    endtask

    // --------------------
    // watchdog
    initial begin
        repeat (timeout_cycles) @(posedge clk);
        $display("the run did not finish within %0d cycles and was stopped", timeout_cycles);
        $display("checks: %0d, errors: %0d", check_count, error_count + 1);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        int rep;
        rst         = 1'b1;
        load_en     = 1'b0;
        load_addr   = '0;
        load_data   = '0;
        lfsr_state  = 32'hc50c;
        check_count = 0;
        error_count = 0;
        checking    = 1'b0;
        prog_done   = 1'b0;
        for (rep = 0; rep < n_programs / 3; rep++) begin
            alu_mix_program();
            run_program();
            load_store_program();
            run_program();
            branch_program(rep[0]);
            run_program();
        end
        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: files.f
src/rv_isa_pkg.sv
src/rv_mem_pkg.sv
src/rv_fetch.sv
src/rv_exec.sv
src/rv_lsu.sv
src/rv_mem_arbiter.sv
src/rv_unified_mem.sv
src/rv_top.sv
bench/rv_arbiter_properties.sv
bench/rv_top_tb.sv
